// File: Makefile
SRCS := $(wildcard verilog/*.sv sim/*.sv)

.PHONY: run clean

obj_dir/VrvDatapathTb: $(SRCS) files.f
	verilator --binary --timing --assert --top-module rvDatapathTb -f files.f -o VrvDatapathTb

run: obj_dir/VrvDatapathTb
	-./obj_dir/VrvDatapathTb > sim.log 2>&1
	cat sim.log
	! grep -q "Verification failed" sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: files.f
verilog/rvPkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/rvDatapath.sv
sim/rvDatapath_checker.sv
sim/rvDatapathTb.sv

// File: sim/rvDatapathTb.sv
// Testbench for the five-stage datapath that acts as controller and instruction memory
// Instructions are issued in slots whose controls follow them down the pipeline
`timescale 1ns/1ps
`default_nettype none

module rvDatapathTb;

    logic clk = 1'b0;
    logic reset, stallF, stallD, flushD, flushE, pcSrcE, regWriteW;
    rvPkg::word_t    instrF, readDataM, pcF, aluResultM, writeDataM;
    rvPkg::immSrc_t  immSrcD;
    rvPkg::exCtrl_t  exCtrl;
    rvPkg::resSrc_t  resultSrcM, resultSrcW;
    rvPkg::decFields_t fields;
    rvPkg::hazRegs_t hazRegs;
    logic zeroE;

    int errors = 0;
    int checks = 0;
    logic [15:0] lfsrState = 16'd17461;

    // Per-slot stimulus and expectations indexed by fetch cycle
    rvPkg::word_t    sInstr [64];
    rvPkg::immSrc_t  sImmSrc [64];
    rvPkg::exCtrl_t  sCtrl [64];
    rvPkg::resSrc_t  sResW [64];
    logic            sWr [64];
    logic            sRedir [64];
    logic            sChk [64];
    logic            sChkWd [64];
    rvPkg::word_t    sRdData [64];
    rvPkg::word_t    sExp [64];
    rvPkg::word_t    sExpWd [64];
    rvPkg::word_t    sImm [64];
    rvPkg::word_t    sPc [64];
    int nSlots;

    rvDatapath dut (
        .clk(clk), .reset(reset), .stallF_i(stallF), .stallD_i(stallD),
        .flushD_i(flushD), .flushE_i(flushE), .pcSrcE_i(pcSrcE), .instrF_i(instrF),
        .immSrcD_i(immSrcD), .exCtrl_i(exCtrl), .regWriteW_i(regWriteW),
        .resultSrcM_i(resultSrcM), .resultSrcW_i(resultSrcW), .readDataM_i(readDataM),
        .pcF_o(pcF), .fields_o(fields), .hazRegs_o(hazRegs), .zeroE_o(zeroE),
        .aluResultM_o(aluResultM), .writeDataM_o(writeDataM)
    );

    always #2 clk = ~clk;

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output rvPkg::word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    function automatic rvPkg::word_t sext12(input rvPkg::word_t v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    // Standard RISC-V encodings with funct3 zero
    function automatic rvPkg::word_t encode(input rvPkg::immSrc_t kind, input rvPkg::word_t imm,
                                            input rvPkg::regAddr_t rs1, input rvPkg::regAddr_t rd);
        case (kind)
            rvPkg::immS: return {imm[11:5], 5'd0, rs1, 3'd0, imm[4:0], 7'b0100011};
            rvPkg::immB: return {imm[12], imm[10:5], 5'd0, rs1, 3'd0, imm[4:1], imm[11],
                                 7'b1100011};
            rvPkg::immJ: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            rvPkg::immU: return {imm[31:12], rd, 7'b0110111};
            default:     return {imm[11:0], rs1, 3'd0, rd, 7'b0010011};
        endcase
    endfunction

    function automatic rvPkg::word_t encR(input logic [6:0] f7, input rvPkg::regAddr_t rs2,
                                          input rvPkg::regAddr_t rs1, input rvPkg::regAddr_t rd);
        return {f7, rs2, rs1, 3'd0, rd, 7'b0110011};
    endfunction

    function automatic rvPkg::word_t fieldsOf(input rvPkg::word_t w);
        return {6'd0, w[6:0], w[14:12], w[30], w[19:15], w[24:20], w[11:7]};
    endfunction

    function automatic rvPkg::exCtrl_t mkCtrl(input logic src, input rvPkg::aluOp_t op,
                                              input rvPkg::fwd_t a, input rvPkg::fwd_t b);
        rvPkg::exCtrl_t c;
        c.aluSrc   = src;
        c.aluOp    = op;
        c.forwardA = a;
        c.forwardB = b;
        return c;
    endfunction

    task automatic checkVal(input string name, input rvPkg::word_t exp, input rvPkg::word_t act);
        checks++;
        assert (act === exp) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic addSlot(input rvPkg::word_t instr, input rvPkg::immSrc_t kind,
                           input rvPkg::exCtrl_t ctrl, input rvPkg::resSrc_t resW,
                           input logic wr, input rvPkg::word_t rdData, input logic chk,
                           input rvPkg::word_t exp, input logic chkWd,
                           input rvPkg::word_t expWd, input logic redir,
                           input rvPkg::word_t imm);
        sInstr[nSlots]  = instr;
        sImmSrc[nSlots] = kind;
        sCtrl[nSlots]   = ctrl;
        sResW[nSlots]   = resW;
        sWr[nSlots]     = wr;
        sRdData[nSlots] = rdData;
        sChk[nSlots]    = chk;
        sExp[nSlots]    = exp;
        sChkWd[nSlots]  = chkWd;
        sExpWd[nSlots]  = expWd;
        sRedir[nSlots]  = redir;
        sImm[nSlots]    = imm;
        nSlots++;
    endtask

    function automatic logic inRange(input int k);
        return (k >= 0) && (k < nSlots);
    endfunction

    // Each cycle drives stage controls for the slot in that stage and then checks outputs
    task automatic runSlots();
        for (int t = 0; t < nSlots + 5; t++) begin
            @(negedge clk);
            instrF = inRange(t) ? sInstr[t] : '0;
            if (inRange(t)) sPc[t] = pcF;
            immSrcD    = inRange(t - 1) ? sImmSrc[t - 1] : rvPkg::immI;
            exCtrl     = inRange(t - 2) ? sCtrl[t - 2] : '0;
            pcSrcE     = inRange(t - 2) ? sRedir[t - 2] : 1'b0;
            // The result source follows the instruction into memory and writeback
            resultSrcM = inRange(t - 3) ? sResW[t - 3] : rvPkg::resAlu;
            readDataM  = inRange(t - 3) ? sRdData[t - 3] : '0;
            resultSrcW = inRange(t - 4) ? sResW[t - 4] : rvPkg::resAlu;
            regWriteW  = inRange(t - 4) ? sWr[t - 4] : 1'b0;
            #1;
            if (inRange(t - 1))
                checkVal("fields", fieldsOf(sInstr[t - 1]), rvPkg::word_t'(fields));
            if (inRange(t - 2))
                checkVal("hazRegs E", {17'd0, sInstr[t - 2][19:15], sInstr[t - 2][24:20],
                         sInstr[t - 2][11:7]}, {17'd0, hazRegs.rs1E, hazRegs.rs2E, hazRegs.rdE});
            if (inRange(t - 3))
                checkVal("rdM", {27'd0, sInstr[t - 3][11:7]}, {27'd0, hazRegs.rdM});
            if (inRange(t - 4))
                checkVal("rdW", {27'd0, sInstr[t - 4][11:7]}, {27'd0, hazRegs.rdW});
            if (inRange(t - 2) && sChk[t - 2])
                checkVal("zeroE", rvPkg::word_t'(sExp[t - 2] == '0), rvPkg::word_t'(zeroE));
            if (inRange(t - 3) && sChk[t - 3])
                checkVal("aluResultM", sExp[t - 3], aluResultM);
            if (inRange(t - 3) && sChkWd[t - 3])
                checkVal("writeDataM", sExpWd[t - 3], writeDataM);
            if (inRange(t - 3) && sRedir[t - 3])
                checkVal("redirect", sPc[t - 3] + sImm[t - 3], pcF);
        end
        nSlots = 0;
    endtask

    task automatic waitPc(input rvPkg::word_t target);
        int n;
        n = 0;
        while (pcF !== target && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (pcF !== target) begin
            $display("PC never reached %h after reset", target);
            errors++;
        end
    endtask

    task automatic stallTest();
        rvPkg::word_t held;
        @(negedge clk);
        stallF = 1'b1;
        held = pcF;
        repeat (2) begin
            @(negedge clk);
            checkVal("stallF hold", held, pcF);
        end
        stallF = 1'b0;
        @(negedge clk);
        checkVal("step after stall", held + 32'd4, pcF);
    endtask

    task automatic flushTest();
        rvPkg::word_t w;
        w = encR(7'b0100000, 5'd2, 5'd1, 5'd9);
        @(negedge clk);
        instrF = w;
        @(negedge clk);
        instrF = '0;
        stallD = 1'b1;
        #1 checkVal("fields before stallD", fieldsOf(w), rvPkg::word_t'(fields));
        @(negedge clk);
        flushD = 1'b1;
        #1 checkVal("stallD hold", fieldsOf(w), rvPkg::word_t'(fields));
        // Flush wins over the stall still held
        @(negedge clk);
        stallD = 1'b0;
        flushD = 1'b0;
        instrF = w;
        #1 checkVal("flushD fields", '0, rvPkg::word_t'(fields));
        @(negedge clk);
        instrF = '0;
        flushE = 1'b1;
        #1 checkVal("fields before flushE", fieldsOf(w), rvPkg::word_t'(fields));
        @(negedge clk);
        flushE = 1'b0;
        #1 checkVal("flushE rdE", '0, rvPkg::word_t'(hazRegs.rdE));
    endtask

    initial begin
        #20000;
        $display("Timeout: the test sequence did not complete");
        $display("Verification failed");
        $finish;
    end

    initial begin
        rvPkg::word_t v, va, vb, iB, i1, i2, i3;
        reset = 1'b1;
        {stallF, stallD, flushD, flushE, pcSrcE, regWriteW} = '0;
        instrF = '0;
        readDataM = '0;
        immSrcD = rvPkg::immI;
        exCtrl = '0;
        resultSrcM = rvPkg::resAlu;
        resultSrcW = rvPkg::resAlu;
        nSlots = 0;
        repeat (4) @(negedge clk);
        checkVal("reset pc", rvPkg::pcStart, pcF);
        checkVal("reset hazRegs", '0, rvPkg::word_t'(hazRegs));
        reset = 1'b0;
        waitPc(rvPkg::pcStart + 32'd4);
        stallTest();

        // Immediates through x0 + imm; B and J also redirect
        takeBits(12, v);
        addSlot(encode(rvPkg::immI, v, 5'd0, 5'd3), rvPkg::immI,
                mkCtrl(1'b1, rvPkg::aluAdd, rvPkg::fwdReg, rvPkg::fwdReg),
                rvPkg::resAlu, 1'b0, '0, 1'b1, sext12(v), 1'b0, '0, 1'b0, '0);
        takeBits(12, v);
        addSlot(encode(rvPkg::immS, v, 5'd0, 5'd0), rvPkg::immS,
                mkCtrl(1'b1, rvPkg::aluAdd, rvPkg::fwdReg, rvPkg::fwdReg),
                rvPkg::resAlu, 1'b0, '0, 1'b1, sext12(v), 1'b0, '0, 1'b0, '0);
        takeBits(12, v);
        iB = {{19{v[11]}}, v[11:0], 1'b0};
        addSlot(encode(rvPkg::immB, iB, 5'd0, 5'd0), rvPkg::immB,
                mkCtrl(1'b1, rvPkg::aluAdd, rvPkg::fwdReg, rvPkg::fwdReg),
                rvPkg::resAlu, 1'b0, '0, 1'b1, iB, 1'b0, '0, 1'b1, iB);
        addSlot(encode(rvPkg::immJ, 32'hFFF04ABE, 5'd0, 5'd1), rvPkg::immJ,
                mkCtrl(1'b1, rvPkg::aluAdd, rvPkg::fwdReg, rvPkg::fwdReg),
                rvPkg::resAlu, 1'b0, '0, 1'b1, 32'hFFF04ABE, 1'b0, '0, 1'b1, 32'hFFF04ABE);
        addSlot(encode(rvPkg::immU, 32'h8AB07000, 5'd0, 5'd2), rvPkg::immU,
                mkCtrl(1'b1, rvPkg::aluAdd, rvPkg::fwdReg, rvPkg::fwdReg),
                rvPkg::resAlu, 1'b0, '0, 1'b1, 32'h8AB07000, 1'b0, '0, 1'b0, '0);
        runSlots();

        // Register writes from read data with the x0 write dropped
        // x0 is read in the same cycle as its write
        takeBits(32, va);
        takeBits(32, vb);
        takeBits(32, v);
        addSlot(encR(7'd0, 5'd0, 5'd0, 5'd1), rvPkg::immI, '0, rvPkg::resMem, 1'b1, va,
                1'b0, '0, 1'b0, '0, 1'b0, '0);
        addSlot(encR(7'd0, 5'd0, 5'd0, 5'd2), rvPkg::immI, '0, rvPkg::resMem, 1'b1, vb,
                1'b0, '0, 1'b0, '0, 1'b0, '0);
        addSlot(encR(7'd0, 5'd0, 5'd0, 5'd0), rvPkg::immI, '0, rvPkg::resMem, 1'b1, v,
                1'b0, '0, 1'b0, '0, 1'b0, '0);
        addSlot('0, rvPkg::immI, '0, rvPkg::resAlu, 1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
        addSlot('0, rvPkg::immI, '0, rvPkg::resAlu, 1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
        addSlot(encR(7'd0, 5'd2, 5'd0, 5'd4), rvPkg::immI, '0, rvPkg::resAlu, 1'b0, '0,
                1'b1, vb, 1'b1, vb, 1'b0, '0);
        addSlot(encR(7'd0, 5'd2, 5'd1, 5'd3), rvPkg::immI, '0, rvPkg::resAlu, 1'b0, '0,
                1'b1, va + vb, 1'b1, vb, 1'b0, '0);
        // Subtracting a register from itself raises the zero flag
        addSlot(encR(7'b0100000, 5'd1, 5'd1, 5'd0), rvPkg::immI,
                mkCtrl(1'b0, rvPkg::aluSub, rvPkg::fwdReg, rvPkg::fwdReg),
                rvPkg::resAlu, 1'b0, '0, 1'b1, va - va, 1'b1, va, 1'b0, '0);
        runSlots();

        // Forwarding from memory, from writeback and through the register file bypass
        takeBits(12, i1);
        takeBits(12, i2);
        takeBits(12, i3);
        addSlot(encode(rvPkg::immI, i1, 5'd0, 5'd5), rvPkg::immI,
                mkCtrl(1'b1, rvPkg::aluAdd, rvPkg::fwdReg, rvPkg::fwdReg),
                rvPkg::resAlu, 1'b1, '0, 1'b1, sext12(i1), 1'b0, '0, 1'b0, '0);
        addSlot(encode(rvPkg::immI, i2, 5'd5, 5'd6), rvPkg::immI,
                mkCtrl(1'b1, rvPkg::aluAdd, rvPkg::fwdMem, rvPkg::fwdMem),
                rvPkg::resAlu, 1'b0, '0, 1'b1, sext12(i1) + sext12(i2), 1'b1, sext12(i1),
                1'b0, '0);
        addSlot(encode(rvPkg::immI, i3, 5'd5, 5'd7), rvPkg::immI,
                mkCtrl(1'b1, rvPkg::aluAdd, rvPkg::fwdWb, rvPkg::fwdReg),
                rvPkg::resAlu, 1'b0, '0, 1'b1, sext12(i1) + sext12(i3), 1'b0, '0, 1'b0, '0);
        addSlot(encR(7'd0, 5'd5, 5'd0, 5'd8), rvPkg::immI,
                mkCtrl(1'b0, rvPkg::aluAdd, rvPkg::fwdReg, rvPkg::fwdReg),
                rvPkg::resAlu, 1'b0, '0, 1'b1, sext12(i1), 1'b1, sext12(i1), 1'b0, '0);
        runSlots();

        flushTest();

        // Bound assertion failures count as errors
        errors += dut.chk.failures;
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/rvDatapath_checker.sv
// Concurrent checks on reset values and PC stepping of the datapath
// Bound into every rvDatapath instance
`timescale 1ns/1ps
`default_nettype none

module rvDatapath_checker (
    input wire                  clk,
    input wire                  reset,
    input wire                  stallF_i,
    input wire                  pcSrcE_i,
    input wire rvPkg::word_t    pcF_o,
    input wire rvPkg::hazRegs_t hazRegs_o
);

    // Number of assertion failures so far
    int failures = 0;

    // Whole pipeline cleared one cycle after reset
    resetValues: assert property (@(posedge clk)
        reset |=> (pcF_o == rvPkg::pcStart) && (hazRegs_o == '0))
        else begin
            failures++;
            $error("PC or hazard indices not cleared after reset");
        end

    // Sequential fetch
    pcStep: assert property (@(posedge clk)
        (!reset && !stallF_i && !pcSrcE_i) |=> (pcF_o == $past(pcF_o) + 32'd4))
        else begin
            failures++;
            $error("PC did not advance by 4");
        end

    pcHold: assert property (@(posedge clk)
        (!reset && stallF_i) |=> (pcF_o == $past(pcF_o)))
        else begin
            failures++;
            $error("PC changed while fetch was stalled");
        end

endmodule

bind rvDatapath rvDatapath_checker chk (
    .clk       (clk),
    .reset     (reset),
    .stallF_i  (stallF_i),
    .pcSrcE_i  (pcSrcE_i),
    .pcF_o     (pcF_o),
    .hazRegs_o (hazRegs_o)
);

`default_nettype wire

// File: verilog/alu.sv
// Execute stage ALU for add, sub, and, or and signed set-less-than
// zero_o flags an all-zero result for branch resolution
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rvPkg::word_t  a_i,
    input  wire rvPkg::word_t  b_i,
    input  wire rvPkg::aluOp_t op_i,
    output rvPkg::word_t       result_o,
    output logic               zero_o
);

    rvPkg::word_t diff;

    // Shared by sub and slt
    assign diff = a_i - b_i;

    always_comb begin
        case (op_i)
            rvPkg::aluAdd: result_o = a_i + b_i;
            rvPkg::aluSub: result_o = diff;
            rvPkg::aluAnd: result_o = a_i & b_i;
            rvPkg::aluOr:  result_o = a_i | b_i;
            rvPkg::aluSlt: begin
                // Signed compare from the sign bits and the difference
                if (a_i[rvPkg::xlen-1] != b_i[rvPkg::xlen-1]) begin
                    result_o = {{(rvPkg::xlen-1){1'b0}}, a_i[rvPkg::xlen-1]};
                end else begin
                    result_o = {{(rvPkg::xlen-1){1'b0}}, diff[rvPkg::xlen-1]};
                end
            end
            default: result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
// Decode stage: fetch-to-decode register, field split, immediate generation
// and register file reads. Writeback writes into the register file from here
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  stallD_i,
    input  wire                  flushD_i,
    input  wire rvPkg::word_t    instrF_i,
    input  wire rvPkg::word_t    pcF_i,
    input  wire rvPkg::word_t    pcPlus4F_i,
    input  wire rvPkg::immSrc_t  immSrcD_i,
    input  wire                  regWriteW_i,
    input  wire rvPkg::regAddr_t rdW_i,
    input  wire rvPkg::word_t    resultW_i,
    output rvPkg::decFields_t    fields_o,
    output rvPkg::decToEx_t      dec_o
);

    rvPkg::instr_t instrD;
    rvPkg::word_t  pcD;
    rvPkg::word_t  pcPlus4D;
    rvPkg::word_t  extImm;
    rvPkg::word_t  rd1;
    rvPkg::word_t  rd2;

    // Flush inserts an all-zero word and overrides stall
    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD   <= '0;
            pcD      <= '0;
            pcPlus4D <= '0;
        end else if (!stallD_i) begin
            instrD   <= instrF_i;
            pcD      <= pcF_i;
            pcPlus4D <= pcPlus4F_i;
        end
    end

    always_comb begin
        fields_o.opcode   = instrD.rView.opcode;
        fields_o.funct3   = instrD.rView.funct3;
        fields_o.funct7b5 = instrD.rView.funct7[5];
        fields_o.rs1      = instrD.rView.rs1;
        fields_o.rs2      = instrD.rView.rs2;
        fields_o.rd       = instrD.rView.rd;
    end

    // immHi[6] is instruction bit 31, the sign of every immediate
    always_comb begin
        case (immSrcD_i)
            rvPkg::immI: extImm = {{20{instrD.sView.immHi[6]}},
                                   instrD.rView.funct7, instrD.rView.rs2};
            rvPkg::immS: extImm = {{20{instrD.sView.immHi[6]}},
                                   instrD.sView.immHi, instrD.sView.immLo};
            rvPkg::immB: extImm = {{20{instrD.sView.immHi[6]}}, instrD.sView.immLo[0],
                                   instrD.sView.immHi[5:0], instrD.sView.immLo[4:1], 1'b0};
            rvPkg::immJ: extImm = {{12{instrD.sView.immHi[6]}},
                                   instrD.rView.rs1, instrD.rView.funct3,
                                   instrD.rView.rs2[0], instrD.rView.funct7[5:0],
                                   instrD.rView.rs2[4:1], 1'b0};
            rvPkg::immU: extImm = {instrD.rView.funct7, instrD.rView.rs2,
                                   instrD.rView.rs1, instrD.rView.funct3, 12'b0};
            default:     extImm = '0;
        endcase
    end

    regFile rf (
        .clk   (clk),
        .ra1_i (instrD.rView.rs1),
        .ra2_i (instrD.rView.rs2),
        .wa_i  (rdW_i),
        .we_i  (regWriteW_i),
        .wd_i  (resultW_i),
        .rd1_o (rd1),
        .rd2_o (rd2)
    );

    always_comb begin
        dec_o.rd1     = rd1;
        dec_o.rd2     = rd2;
        dec_o.pc      = pcD;
        dec_o.pcPlus4 = pcPlus4D;
        dec_o.extImm  = extImm;
        dec_o.rs1     = instrD.rView.rs1;
        dec_o.rs2     = instrD.rView.rs2;
        dec_o.rd      = instrD.rView.rd;
    end

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
// Execute stage: decode-to-execute register, operand forwarding, ALU and
// branch target adder. The forwarded rs2 value also serves as store data
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  flushE_i,
    input  wire rvPkg::decToEx_t dec_i,
    input  wire rvPkg::exCtrl_t  ctrl_i,
    input  wire rvPkg::word_t    fwdM_i,
    input  wire rvPkg::word_t    resultW_i,
    output rvPkg::exToMem_t      ex_o,
    output rvPkg::regAddr_t      rs1E_o,
    output rvPkg::regAddr_t      rs2E_o,
    output rvPkg::regAddr_t      rdE_o,
    output logic                 zeroE_o,
    output rvPkg::word_t         pcTargetE_o
);

    rvPkg::decToEx_t decE;
    rvPkg::word_t    srcA;
    rvPkg::word_t    srcB;
    rvPkg::word_t    writeData;
    rvPkg::word_t    aluResult;

    // Unused forward code falls back to the register value
    function automatic rvPkg::word_t fwdSel(
        input rvPkg::fwd_t  sel,
        input rvPkg::word_t regVal,
        input rvPkg::word_t wbVal,
        input rvPkg::word_t memVal
    );
        case (sel)
            rvPkg::fwdWb:  return wbVal;
            rvPkg::fwdMem: return memVal;
            default:       return regVal;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            decE <= '0;
        end else begin
            decE <= dec_i;
        end
    end

    assign srcA      = fwdSel(ctrl_i.forwardA, decE.rd1, resultW_i, fwdM_i);
    assign writeData = fwdSel(ctrl_i.forwardB, decE.rd2, resultW_i, fwdM_i);
    assign srcB      = ctrl_i.aluSrc ? decE.extImm : writeData;

    alu aluUnit (
        .a_i      (srcA),
        .b_i      (srcB),
        .op_i     (ctrl_i.aluOp),
        .result_o (aluResult),
        .zero_o   (zeroE_o)
    );

    // Target for branches and jal, resolved here
    assign pcTargetE_o = decE.pc + decE.extImm;

    assign rs1E_o = decE.rs1;
    assign rs2E_o = decE.rs2;
    assign rdE_o  = decE.rd;

    always_comb begin
        ex_o.aluResult = aluResult;
        ex_o.writeData = writeData;
        ex_o.extImm    = decE.extImm;
        ex_o.pcPlus4   = decE.pcPlus4;
        ex_o.rd        = decE.rd;
    end

endmodule

`default_nettype wire

// File: verilog/fetchStage.sv
// Fetch stage holding the program counter
// Steps by 4 unless stalled, or jumps to the execute-stage target on redirect
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  wire               clk,
    input  wire               reset,
    input  wire               stallF_i,
    input  wire               pcSrcE_i,
    input  wire rvPkg::word_t pcTargetE_i,
    output rvPkg::word_t      pcF_o,
    output rvPkg::word_t      pcPlus4F_o
);

    rvPkg::word_t pcNext;

    assign pcPlus4F_o = pcF_o + rvPkg::xlen'(4);

    // Redirect wins over sequential flow
    assign pcNext = pcSrcE_i ? pcTargetE_i : pcPlus4F_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= rvPkg::pcStart;
        end else if (!stallF_i) begin
            pcF_o <= pcNext;
        end
    end

endmodule

`default_nettype wire

// File: verilog/memWbStage.sv
// Memory and writeback pipeline registers with their result muxes
// fwdM_o feeds execute forwarding; resultW_o goes to the register file
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
    input  wire                  clk,
    input  wire                  reset,
    input  wire rvPkg::exToMem_t ex_i,
    input  wire rvPkg::word_t    readDataM_i,
    input  wire rvPkg::resSrc_t  resultSrcM_i,
    input  wire rvPkg::resSrc_t  resultSrcW_i,
    output rvPkg::word_t         aluResultM_o,
    output rvPkg::word_t         writeDataM_o,
    output rvPkg::word_t         fwdM_o,
    output rvPkg::regAddr_t      rdM_o,
    output rvPkg::regAddr_t      rdW_o,
    output rvPkg::word_t         resultW_o
);

    typedef struct packed {
        rvPkg::word_t    aluResult;
        rvPkg::word_t    readData;
        rvPkg::word_t    extImm;
        rvPkg::word_t    pcPlus4;
        rvPkg::regAddr_t rd;
    } wbRegs_t;

    rvPkg::exToMem_t exM;
    wbRegs_t         wb;

    always_ff @(posedge clk) begin
        if (reset) begin
            exM <= '0;
            wb  <= '0;
        end else begin
            exM         <= ex_i;
            wb.aluResult <= exM.aluResult;
            wb.readData  <= readDataM_i;
            wb.extImm    <= exM.extImm;
            wb.pcPlus4   <= exM.pcPlus4;
            wb.rd        <= exM.rd;
        end
    end

    assign aluResultM_o = exM.aluResult;
    assign writeDataM_o = exM.writeData;
    assign rdM_o        = exM.rd;
    assign rdW_o        = wb.rd;

    // Load data is not available yet in memory, so loads forward the ALU value
    always_comb begin
        case (resultSrcM_i)
            rvPkg::resPc4: fwdM_o = exM.pcPlus4;
            rvPkg::resImm: fwdM_o = exM.extImm;
            default:       fwdM_o = exM.aluResult;
        endcase
    end

    always_comb begin
        case (resultSrcW_i)
            rvPkg::resMem: resultW_o = wb.readData;
            rvPkg::resPc4: resultW_o = wb.pcPlus4;
            rvPkg::resImm: resultW_o = wb.extImm;
            default:       resultW_o = wb.aluResult;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/regFile.sv
// Integer register file with two combinational read ports and one write port
// Reads of the register being written return the incoming write data
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire               clk,
    input  wire rvPkg::regAddr_t ra1_i,
    input  wire rvPkg::regAddr_t ra2_i,
    input  wire rvPkg::regAddr_t wa_i,
    input  wire               we_i,
    input  wire rvPkg::word_t wd_i,
    output rvPkg::word_t      rd1_o,
    output rvPkg::word_t      rd2_o
);

    rvPkg::word_t regs [2**rvPkg::regAddrBits];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (we_i && (wa_i != '0)) begin
            regs[wa_i] <= wd_i;
        end
    end

    // Zero for x0, then bypass of a same-cycle write, then the stored word
    assign rd1_o = (ra1_i == '0)             ? '0   :
                   (we_i && (ra1_i == wa_i)) ? wd_i : regs[ra1_i];

    assign rd2_o = (ra2_i == '0)             ? '0   :
                   (we_i && (ra2_i == wa_i)) ? wd_i : regs[ra2_i];

endmodule

`default_nettype wire

// File: verilog/rvDatapath.sv
// Top of the five-stage datapath, steered by an outside controller
// Instruction and data memories sit outside and answer combinationally
`timescale 1ns/1ps
`default_nettype none

module rvDatapath (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  stallF_i,
    input  wire                  stallD_i,
    input  wire                  flushD_i,
    input  wire                  flushE_i,
    input  wire                  pcSrcE_i,
    input  wire rvPkg::word_t    instrF_i,
    input  wire rvPkg::immSrc_t  immSrcD_i,
    input  wire rvPkg::exCtrl_t  exCtrl_i,
    input  wire                  regWriteW_i,
    input  wire rvPkg::resSrc_t  resultSrcM_i,
    input  wire rvPkg::resSrc_t  resultSrcW_i,
    input  wire rvPkg::word_t    readDataM_i,
    output rvPkg::word_t         pcF_o,
    output rvPkg::decFields_t    fields_o,
    output rvPkg::hazRegs_t      hazRegs_o,
    output logic                 zeroE_o,
    output rvPkg::word_t         aluResultM_o,
    output rvPkg::word_t         writeDataM_o
);

    rvPkg::word_t    pcPlus4F;
    rvPkg::word_t    pcTargetE;
    rvPkg::decToEx_t decToEx;
    rvPkg::exToMem_t exToMem;
    rvPkg::word_t    fwdM;
    rvPkg::word_t    resultW;
    rvPkg::regAddr_t rs1E;
    rvPkg::regAddr_t rs2E;
    rvPkg::regAddr_t rdE;
    rvPkg::regAddr_t rdM;
    rvPkg::regAddr_t rdW;

    fetchStage fetch (
        .clk         (clk),
        .reset       (reset),
        .stallF_i    (stallF_i),
        .pcSrcE_i    (pcSrcE_i),
        .pcTargetE_i (pcTargetE),
        .pcF_o       (pcF_o),
        .pcPlus4F_o  (pcPlus4F)
    );

    decodeStage decode (
        .clk         (clk),
        .reset       (reset),
        .stallD_i    (stallD_i),
        .flushD_i    (flushD_i),
        .instrF_i    (instrF_i),
        .pcF_i       (pcF_o),
        .pcPlus4F_i  (pcPlus4F),
        .immSrcD_i   (immSrcD_i),
        .regWriteW_i (regWriteW_i),
        .rdW_i       (rdW),
        .resultW_i   (resultW),
        .fields_o    (fields_o),
        .dec_o       (decToEx)
    );

    executeStage execute (
        .clk         (clk),
        .reset       (reset),
        .flushE_i    (flushE_i),
        .dec_i       (decToEx),
        .ctrl_i      (exCtrl_i),
        .fwdM_i      (fwdM),
        .resultW_i   (resultW),
        .ex_o        (exToMem),
        .rs1E_o      (rs1E),
        .rs2E_o      (rs2E),
        .rdE_o       (rdE),
        .zeroE_o     (zeroE_o),
        .pcTargetE_o (pcTargetE)
    );

    memWbStage memWb (
        .clk          (clk),
        .reset        (reset),
        .ex_i         (exToMem),
        .readDataM_i  (readDataM_i),
        .resultSrcM_i (resultSrcM_i),
        .resultSrcW_i (resultSrcW_i),
        .aluResultM_o (aluResultM_o),
        .writeDataM_o (writeDataM_o),
        .fwdM_o       (fwdM),
        .rdM_o        (rdM),
        .rdW_o        (rdW),
        .resultW_o    (resultW)
    );

    // Field order follows hazRegs_t
    assign hazRegs_o = {rs1E, rs2E, rdE, rdM, rdW};

endmodule

`default_nettype wire

// File: verilog/rvPkg.sv
// Shared widths, control encodings and pipeline payload types for the datapath
// Every datapath file refers to these by rvPkg:: scoped names
`default_nettype none

package rvPkg;

    localparam int xlen        = 32;
    localparam int regAddrBits = 5;

    typedef logic [xlen-1:0]        word_t;
    typedef logic [regAddrBits-1:0] regAddr_t;

    localparam word_t pcStart = '0;

    // Immediate layout selected by the controller in decode
    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immSrc_t;

    // Operand source for the execute stage forwarding muxes
    typedef enum logic [1:0] {
        fwdReg = 2'b00,
        fwdWb  = 2'b01,
        fwdMem = 2'b10
    } fwd_t;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluOp_t;

    typedef enum logic [1:0] {
        resAlu = 2'b00,
        resMem = 2'b01,
        resPc4 = 2'b10,
        resImm = 2'b11
    } resSrc_t;

    // Register-type and store-type views of one instruction word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            regAddr_t   rs2;
            regAddr_t   rs1;
            logic [2:0] funct3;
            regAddr_t   rd;
            logic [6:0] opcode;
        } rView;
        struct packed {
            logic [6:0] immHi;
            regAddr_t   rs2;
            regAddr_t   rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sView;
    } instr_t;

    // Decoded fields handed to the controller
    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic       funct7b5;
        regAddr_t   rs1;
        regAddr_t   rs2;
        regAddr_t   rd;
    } decFields_t;

    // Execute controls, aluSrc high takes the immediate as operand B
    typedef struct packed {
        logic   aluSrc;
        aluOp_t aluOp;
        fwd_t   forwardA;
        fwd_t   forwardB;
    } exCtrl_t;

    typedef struct packed {
        regAddr_t rs1E;
        regAddr_t rs2E;
        regAddr_t rdE;
        regAddr_t rdM;
        regAddr_t rdW;
    } hazRegs_t;

    typedef struct packed {
        word_t    rd1;
        word_t    rd2;
        word_t    pc;
        word_t    pcPlus4;
        word_t    extImm;
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
    } decToEx_t;

    typedef struct packed {
        word_t    aluResult;
        word_t    writeData;
        word_t    extImm;
        word_t    pcPlus4;
        regAddr_t rd;
    } exToMem_t;

endpackage

`default_nettype wire
